/* adc_ssi_macros.svh */
// ******************************
// Width and lane count macros for the ADC serial receive path
// ******************************

`ifndef ADC_SSI_MACROS_SVH
`define ADC_SSI_MACROS_SVH

// Bits per conversion result as shifted out by the ADC
`define ADC_SAMPLE_WIDTH 20

// Width of the sign-extended sample handed to the consumer
`define ADC_OUT_WIDTH 24

// Number of active data lanes, 1 (da only) or 2 (da and db)
// With two lanes da carries bit i and db carries bit i-1 in the same cycle
`define ADC_LANES 2

// Width of the wrapping frame sequence number
`define ADC_SEQ_WIDTH 4

`endif

/* adc_ssi_pkg.sv */
// ******************************
// Shared types: raw word union, lane bits and output sample
// ******************************

`include "adc_ssi_macros.svh"

package adc_ssi_pkg;

  // ******************************
  // Raw conversion word
  // ******************************

  // The ADC word is interpreted in one of two number formats
  // Both views cover the same bits, the formatter picks one at run time
  typedef union packed {
    // Unsigned offset binary, mid scale is 80000 hex
    logic        [`ADC_SAMPLE_WIDTH-1:0] ob;
    // Signed two's complement, zero is 00000 hex
    logic signed [`ADC_SAMPLE_WIDTH-1:0] tc;
  } adc_raw_u;

  // ******************************
  // Lane and output words
  // ******************************

  // Bits seen on the data lanes in one ssi_clk cycle
  // db is ignored when only one lane is in use
  typedef struct packed {
    logic da;
    logic db;
  } adc_lane_bits_t;

  // Sample presented on the req/ack output
  typedef struct packed {
    // Sign-extended conversion result
    logic signed [`ADC_OUT_WIDTH-1:0] sample;
    // Frame number, wraps and shows gaps where frames were dropped
    logic        [`ADC_SEQ_WIDTH-1:0] seq;
  } adc_sample_t;

endpackage

/* adc_lane_deser.sv */
// ******************************
// Lane deserializer, one raw word per conversion frame
// ******************************

`timescale 1ns/1ps

`include "adc_ssi_macros.svh"

module adc_lane_deser (
  input  logic                        ssi_clk,
  input  logic                        arst_n,
  input  logic                        cnv,
  input  adc_ssi_pkg::adc_lane_bits_t lanes,
  output logic                        raw_valid,
  output adc_ssi_pkg::adc_raw_u       raw
);

  localparam int W     = `ADC_SAMPLE_WIDTH;
  localparam int LANES = `ADC_LANES;
  // Number of ssi_clk cycles that carry data in one frame
  localparam int NBITS = W / LANES;
  localparam int CNT_W = $clog2(NBITS + 1);

  logic [LANES-1:0] lane_bits;
  logic [W-1:0]     shift_q;
  logic [W-1:0]     shift_d;
  logic [CNT_W-1:0] cnt_q;
  logic             active;
  logic             last_bit;

  // ******************************
  // Lane selection
  // ******************************

  // With two lanes da holds the more significant bit of the pair
  generate
    if (LANES == 2) begin : g_two_lanes
      assign lane_bits = {lanes.da, lanes.db};
    end else begin : g_one_lane
      assign lane_bits = lanes.da;
    end
  endgenerate

  // MSB arrives first, so new bits enter at the bottom and move up
  assign shift_d = {shift_q[W-LANES-1:0], lane_bits};

  // The counter is non zero for the data cycles of a frame
  assign active   = (cnt_q != '0);
  // Final data cycle of the frame
  assign last_bit = (cnt_q == CNT_W'(1));

  // ******************************
  // Frame control
  // ******************************

  always_ff @(posedge ssi_clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q     <= '0;
      raw_valid <= 1'b0;
    end else begin
      raw_valid <= 1'b0;
      // A strobe always starts a fresh frame, even in the middle of one
      if (cnv) begin
        cnt_q <= CNT_W'(NBITS);
      end else if (active) begin
        cnt_q <= cnt_q - 1'b1;
      end
      // The word is complete with the last bit, unless a new strobe cut it off
      if (!cnv && last_bit) begin
        raw_valid <= 1'b1;
      end
    end
  end

  // ******************************
  // Data path
  // ******************************

  // Every data cycle overwrites LANES bits, so a full frame replaces the whole word
  // Leftover bits from an aborted frame are pushed out by the restarted one
  always_ff @(posedge ssi_clk) begin
    if (active) begin
      shift_q <= shift_d;
    end
    // Take the word including the bits of the last cycle, saving one cycle of latency
    if (!cnv && last_bit) begin
      raw.ob <= shift_d;
    end
  end

endmodule

/* adc_sample_format.sv */
// ******************************
// Number format decode and sign extension
// ******************************

`timescale 1ns/1ps

`include "adc_ssi_macros.svh"

module adc_sample_format (
  input  logic                            ssi_clk,
  input  logic                            arst_n,
  input  logic                            raw_valid,
  input  adc_ssi_pkg::adc_raw_u           raw,
  input  logic                            fmt_twos,
  output logic                            fmt_valid,
  output logic signed [`ADC_OUT_WIDTH-1:0] fmt_sample
);

  localparam int W  = `ADC_SAMPLE_WIDTH;
  localparam int OW = `ADC_OUT_WIDTH;

  logic [W-1:0]  ob_word;
  logic [OW-1:0] ext_ob;
  logic [OW-1:0] ext_tc;

  // Offset binary becomes two's complement by flipping the MSB
  assign ob_word = {~raw.ob[W-1], raw.ob[W-2:0]};

  // Replicate the resulting sign bit into the upper bits
  assign ext_ob = {{(OW-W){ob_word[W-1]}}, ob_word};
  assign ext_tc = {{(OW-W){raw.tc[W-1]}}, raw.tc};

  // Valid follows the raw word by exactly one cycle
  always_ff @(posedge ssi_clk or negedge arst_n) begin
    if (!arst_n) begin
      fmt_valid <= 1'b0;
    end else begin
      fmt_valid <= raw_valid;
    end
  end

  // fmt_twos is quasi static, it is only looked at when a word arrives
  always_ff @(posedge ssi_clk) begin
    if (raw_valid) begin
      fmt_sample <= fmt_twos ? ext_tc : ext_ob;
    end
  end

endmodule

/* adc_sample_handoff.sv */
// ******************************
// Sample holding register with four-phase req/ack output
// ******************************

`timescale 1ns/1ps

`include "adc_ssi_macros.svh"

module adc_sample_handoff (
  input  logic                             ssi_clk,
  input  logic                             arst_n,
  input  logic                             fmt_valid,
  input  logic signed [`ADC_OUT_WIDTH-1:0] fmt_sample,
  output logic                             out_req,
  input  logic                             out_ack,
  output adc_ssi_pkg::adc_sample_t         out_data,
  output logic                             overrun
);

  localparam int SW = `ADC_SEQ_WIDTH;

  logic [SW-1:0] seq_q;
  logic          idle;

  // A new transfer may only start once both phases have returned low
  assign idle = !out_req && !out_ack;

  // ******************************
  // Handshake and status
  // ******************************

  always_ff @(posedge ssi_clk or negedge arst_n) begin
    if (!arst_n) begin
      seq_q   <= '0;
      out_req <= 1'b0;
      overrun <= 1'b0;
    end else begin
      // Every frame gets a number, delivered or not
      if (fmt_valid) begin
        seq_q <= seq_q + 1'b1;
      end
      if (fmt_valid && idle) begin
        // Phase one, offer the sample
        out_req <= 1'b1;
      end else if (out_req && out_ack) begin
        // Phase three, withdraw the request after the acknowledge
        out_req <= 1'b0;
      end
      // A sample that finds the handshake busy is lost and the flag sticks
      if (fmt_valid && !idle) begin
        overrun <= 1'b1;
      end
    end
  end

  // ******************************
  // Holding register
  // ******************************

  // Loaded only when idle, so the data stays put for the whole transfer
  always_ff @(posedge ssi_clk) begin
    if (fmt_valid && idle) begin
      out_data.sample <= fmt_sample;
      out_data.seq    <= seq_q;
    end
  end

endmodule

/* adc_ssi_rx.sv */
// ******************************
// Receive path top: deserializer, formatter and handoff
// ******************************

`timescale 1ns/1ps

`include "adc_ssi_macros.svh"

module adc_ssi_rx (
  input  logic                        ssi_clk,
  input  logic                        arst_n,
  input  logic                        cnv,
  input  adc_ssi_pkg::adc_lane_bits_t lanes,
  input  logic                        fmt_twos,
  output logic                        out_req,
  input  logic                        out_ack,
  output adc_ssi_pkg::adc_sample_t    out_data,
  output logic                        overrun
);

  import adc_ssi_pkg::*;

  // Deserializer to formatter
  logic     raw_valid;
  adc_raw_u raw;

  // Formatter to handoff
  logic                             fmt_valid;
  logic signed [`ADC_OUT_WIDTH-1:0] fmt_sample;

  // Collects the lane bits of one frame into a raw word
  adc_lane_deser u_deser (
    .ssi_clk   (ssi_clk),
    .arst_n    (arst_n),
    .cnv       (cnv),
    .lanes     (lanes),
    .raw_valid (raw_valid),
    .raw       (raw)
  );

  // Interprets the raw word and widens it to the output width
  adc_sample_format u_format (
    .ssi_clk    (ssi_clk),
    .arst_n     (arst_n),
    .raw_valid  (raw_valid),
    .raw        (raw),
    .fmt_twos   (fmt_twos),
    .fmt_valid  (fmt_valid),
    .fmt_sample (fmt_sample)
  );

  // Numbers the sample and passes it to the consumer
  adc_sample_handoff u_handoff (
    .ssi_clk    (ssi_clk),
    .arst_n     (arst_n),
    .fmt_valid  (fmt_valid),
    .fmt_sample (fmt_sample),
    .out_req    (out_req),
    .out_ack    (out_ack),
    .out_data   (out_data),
    .overrun    (overrun)
  );

endmodule

/* adc_ssi_checker.sv */
// ******************************
// Handshake and reset assertions, bound into the receive path top
// ******************************

`timescale 1ns/1ps

module adc_ssi_checker (
  input logic                     ssi_clk,
  input logic                     arst_n,
  input logic                     out_req,
  input logic                     out_ack,
  input adc_ssi_pkg::adc_sample_t out_data,
  input logic                     overrun
);

  // The holding register must not move while a request is open
  property p_data_stable;
    @(posedge ssi_clk) disable iff (!arst_n)
      out_req && $past(out_req) |-> out_data == $past(out_data);
  endproperty

  // A new request needs the acknowledge of the previous one to be gone
  property p_req_after_ack;
    @(posedge ssi_clk) disable iff (!arst_n)
      $rose(out_req) |-> !$past(out_ack);
  endproperty

  // Overrun only clears through reset
  property p_overrun_sticky;
    @(posedge ssi_clk) disable iff (!arst_n)
      !$fell(overrun);
  endproperty

  a_data_stable: assert property (p_data_stable)
    else $error("out_data changed while out_req was high");

  a_req_after_ack: assert property (p_req_after_ack)
    else $error("out_req rose while out_ack was still high");

  a_overrun_sticky: assert property (p_overrun_sticky)
    else $error("overrun fell while reset was inactive");

endmodule

bind adc_ssi_rx adc_ssi_checker u_checker (
  .ssi_clk  (ssi_clk),
  .arst_n   (arst_n),
  .out_req  (out_req),
  .out_ack  (out_ack),
  .out_data (out_data),
  .overrun  (overrun)
);

/* tb_adc_ssi_rx.sv */
// ******************************
// Testbench for the ADC serial receive path: frame driver, consumer,
// reference model and reporting
// ******************************

`timescale 1ns/1ps

`include "adc_ssi_macros.svh"

module tb_adc_ssi_rx;

  import adc_ssi_pkg::*;

  localparam int W       = `ADC_SAMPLE_WIDTH;
  localparam int LANES   = `ADC_LANES;
  // Data cycles per frame
  localparam int N       = W / LANES;
  localparam int SEQ_MOD = 1 << `ADC_SEQ_WIDTH;
  // Frames of all tests, aborted partial frames included
  localparam int TOTAL_FRAMES = 50 + 50 + 8 + 30 + 3;
  localparam int CYCLE_LIMIT  = TOTAL_FRAMES * 30 + 200;

  logic           ssi_clk = 1'b0;
  logic           arst_n;
  logic           cnv;
  adc_lane_bits_t lanes;
  logic           fmt_twos;
  logic           out_req;
  logic           out_ack;
  adc_sample_t    out_data;
  logic           overrun;

  // Expected frames in send order, and samples seen by the consumer
  int          exp_val_q[$];
  int          exp_idx_q[$];
  adc_sample_t rx_q[$];

  int frame_idx     = 0;
  int max_ack_delay = 3;
  int last_dropped  = 0;
  int cycles        = 0;
  int checks        = 0;
  int errors        = 0;
  int test_errors   = 0;
  int tests_run     = 0;
  int tests_failed  = 0;

  always #2 ssi_clk = ~ssi_clk;

  adc_ssi_rx uut (
    .ssi_clk  (ssi_clk),
    .arst_n   (arst_n),
    .cnv      (cnv),
    .lanes    (lanes),
    .fmt_twos (fmt_twos),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_data (out_data),
    .overrun  (overrun)
  );

  // ******************************
  // Reporting
  // ******************************

  task automatic flag_mismatch(input string what, input int got, input int exp);
    $display("Fail at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
    test_errors++;
  endtask

  task automatic note_problem(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    test_errors++;
  endtask

  task automatic begin_test();
    test_errors = 0;
    tests_run++;
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      $display("Test %0d %s: %0d errors", tests_run, name, test_errors);
      tests_failed++;
    end
    errors += test_errors;
  endtask

  // ******************************
  // Reference model
  // ******************************

  // Value of the raw word as a signed integer in the chosen number format
  function automatic int expected_value(input logic [W-1:0] word, input logic twos);
    int u;
    u = int'(word);
    if (!twos) begin
      // Offset binary, mid scale maps to zero
      return u - (1 << (W - 1));
    end
    if (u >= (1 << (W - 1))) begin
      return u - (1 << W);
    end
    return u;
  endfunction

  // Matches received samples to sent frames by seq, counting frames that never arrived
  task automatic check_received(input bit allow_drops);
    adc_sample_t got;
    int          exp_v;
    int          exp_i;
    int          dropped;
    bit          found;
    dropped = 0;
    exp_v   = 0;
    exp_i   = 0;
    while (rx_q.size() > 0) begin
      got   = rx_q.pop_front();
      found = 1'b0;
      while (!found && exp_val_q.size() > 0) begin
        exp_v = exp_val_q.pop_front();
        exp_i = exp_idx_q.pop_front();
        if (exp_i % SEQ_MOD == int'(got.seq)) begin
          found = 1'b1;
        end else begin
          dropped++;
        end
      end
      checks++;
      if (!found) begin
        note_problem($sformatf("sample with seq %0d matches no frame that was sent", got.seq));
      end else if (int'(got.sample) != exp_v) begin
        flag_mismatch($sformatf("sample of frame %0d", exp_i), int'(got.sample), exp_v);
      end
    end
    // Frames still queued were sent but never handed over
    dropped += exp_val_q.size();
    exp_val_q.delete();
    exp_idx_q.delete();
    checks++;
    if (!allow_drops && dropped != 0) begin
      note_problem($sformatf("%0d frames were sent but never delivered", dropped));
    end
    last_dropped = dropped;
  endtask

  // ******************************
  // Frame driver
  // ******************************

  // One cnv cycle, then N data cycles MSB first, then an idle gap
  task automatic send_frame(input logic [W-1:0] word, input int gap);
    int b;
    @(posedge ssi_clk);
    cnv   <= 1'b1;
    lanes <= 2'($urandom);
    for (int i = 0; i < N; i++) begin
      b = W - LANES * (i + 1);
      @(posedge ssi_clk);
      cnv <= 1'b0;
      if (LANES == 2) begin
        lanes.da <= word[b + 1];
        lanes.db <= word[b];
      end else begin
        lanes.da <= word[b];
        lanes.db <= 1'($urandom);
      end
    end
    repeat (gap) begin
      @(posedge ssi_clk);
      lanes <= 2'($urandom);
    end
  endtask

  // Starts a frame and cuts it off after k data cycles
  task automatic abort_frame(input int k);
    @(posedge ssi_clk);
    cnv   <= 1'b1;
    lanes <= 2'($urandom);
    repeat (k) begin
      @(posedge ssi_clk);
      cnv   <= 1'b0;
      lanes <= 2'($urandom);
    end
  endtask

  // Records the expected result, then sends the frame
  task automatic queue_frame(input logic [W-1:0] word, input int gap);
    exp_val_q.push_back(expected_value(word, fmt_twos));
    exp_idx_q.push_back(frame_idx);
    frame_idx++;
    send_frame(word, gap);
  endtask

  // The sample reaches the handoff 3 cycles after the last bit
  task automatic wait_idle();
    repeat (5) @(posedge ssi_clk);
    do @(negedge ssi_clk); while (out_req || out_ack);
  endtask

  // Counts rising edges from the cnv cycle up to the one that raises out_req
  task automatic measure_latency(output int lat);
    lat = 0;
    do @(negedge ssi_clk); while (!cnv);
    do begin
      @(posedge ssi_clk);
      lat++;
      @(negedge ssi_clk);
    end while (!out_req);
  endtask

  // ******************************
  // Consumer
  // ******************************

  initial begin : consumer
    int          d;
    adc_sample_t held;
    out_ack <= 1'b0;
    forever begin
      @(negedge ssi_clk);
      if (out_req) begin
        held = out_data;
        rx_q.push_back(held);
        d = $urandom_range(max_ack_delay, 0);
        repeat (d) @(posedge ssi_clk);
        @(posedge ssi_clk);
        out_ack <= 1'b1;
        do begin
          @(negedge ssi_clk);
          if (out_req && out_data != held) begin
            note_problem("out_data changed while out_req was high");
          end
        end while (out_req);
        @(posedge ssi_clk);
        out_ack <= 1'b0;
      end
    end
  end

  // Overrun is sticky once set
  initial begin : overrun_watch
    logic seen;
    seen = 1'b0;
    forever begin
      @(negedge ssi_clk);
      if (arst_n && seen && !overrun) begin
        note_problem("overrun fell without a reset");
      end
      seen = overrun && arst_n;
    end
  end

  initial begin : watchdog
    while (cycles < CYCLE_LIMIT) begin
      @(posedge ssi_clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Verification failed");
    $finish;
  end

  // ******************************
  // Test sequence
  // ******************************

  initial begin : main
    int seed;
    int lat;
    seed = $urandom(32'h5e66);
    cnv      <= 1'b0;
    lanes    <= '0;
    fmt_twos <= 1'b1;
    arst_n   <= 1'b0;
    repeat (4) @(posedge ssi_clk);
    arst_n <= 1'b1;

    // Quiet outputs and no transfer without a conversion
    begin_test();
    repeat (20) begin
      @(negedge ssi_clk);
      checks++;
      if (out_req || overrun) begin
        note_problem("out_req or overrun is high before any conversion");
      end
    end
    checks++;
    if (rx_q.size() != 0) begin
      note_problem("a sample was handed over before the first cnv");
    end
    end_test("reset state");

    begin_test();
    repeat (50) queue_frame(W'($urandom), $urandom_range(6, 0));
    wait_idle();
    check_received(1'b0);
    end_test("twos complement");

    begin_test();
    @(posedge ssi_clk);
    fmt_twos <= 1'b0;
    // The model reads the new format only once it has taken effect
    @(posedge ssi_clk);
    queue_frame('0, 2);
    queue_frame(W'(1 << (W - 1)), 0);
    queue_frame('1, 3);
    repeat (47) queue_frame(W'($urandom), $urandom_range(6, 0));
    wait_idle();
    check_received(1'b0);
    end_test("offset binary");

    // A restarted frame replaces the partial one
    begin_test();
    @(posedge ssi_clk);
    fmt_twos <= 1'b1;
    repeat (4) begin
      abort_frame($urandom_range(N - 1, 1));
      queue_frame(W'($urandom), $urandom_range(6, 0));
    end
    wait_idle();
    check_received(1'b0);
    end_test("aborted frame");

    begin_test();
    max_ack_delay = 40;
    repeat (30) queue_frame(W'($urandom), 0);
    wait_idle();
    check_received(1'b1);
    checks++;
    if (!overrun) begin
      note_problem("overrun stayed low under back-pressure");
    end
    max_ack_delay = 3;
    end_test($sformatf("back-pressure, %0d dropped", last_dropped));

    begin_test();
    repeat (3) begin
      fork
        queue_frame(W'($urandom), 0);
        measure_latency(lat);
      join
      checks++;
      if (lat != N + 3) begin
        flag_mismatch("cnv to out_req latency", lat, N + 3);
      end
      wait_idle();
    end
    check_received(1'b0);
    end_test("latency");

    $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+.
adc_ssi_pkg.sv
adc_lane_deser.sv
adc_sample_format.sv
adc_sample_handoff.sv
adc_ssi_rx.sv
adc_ssi_checker.sv
tb_adc_ssi_rx.sv

/* Makefile */
TOP = tb_adc_ssi_rx

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
